//--- common/panel_cfg.svh
/* Panel geometry for the fill subsystem. Width and height must each stay below 256,
   and BYTES_PER_PIXEL must fit the 2-bit pixel select */
`ifndef PANEL_CFG_SVH
`define PANEL_CFG_SVH

// **********************************************************************
// Panel size in pixels
// **********************************************************************
`define PANEL_WIDTH 16
`define PANEL_HEIGHT 8

// **********************************************************************
// Colour depth, one byte per channel
// **********************************************************************
`define BYTES_PER_PIXEL 3

`endif

//--- common/panel_pkg.sv
/* Pixel geometry and frame-buffer write types. Row and column are 8 bits wide
   so that command arguments can point past the panel and get clipped */
`include "panel_cfg.svh"

package panel_pkg;

    typedef logic [7:0] column_t;
    typedef logic [7:0] row_t;
    typedef logic [1:0] pixel_sel_t;

    // Byte 0 is the first colour byte on the stream and lands at pixel select 0
    typedef logic [`BYTES_PER_PIXEL-1:0][7:0] color_t;

    typedef struct packed {
        row_t       row;
        column_t    column;
        pixel_sel_t sel;
    } pixel_addr_t;

    typedef struct packed {
        pixel_addr_t addr;
        logic [7:0]  data;
        logic        write_en;
    } fb_write_t;

endpackage

//--- common/cmd_pkg.sv
/* Drawing command opcodes and argument layouts. Width and height are not
   limited to the panel, the area filler clips them */

package cmd_pkg;

    // **********************************************************************
    // Opcodes, the first byte of every command
    // **********************************************************************
    typedef enum logic [7:0] {
        OP_FILL_PANEL = 8'h01,
        OP_FILL_RECT  = 8'h02
    } opcode_t;

    // **********************************************************************
    // Rectangle arguments, sent on the stream as x, y, width, height
    // **********************************************************************
    typedef struct packed {
        panel_pkg::column_t x;
        panel_pkg::row_t    y;
        logic [7:0]         width;
        logic [7:0]         height;
    } rect_t;

endpackage

//--- fill/fill_area.sv
/* Writes one colour byte per cycle over a rectangle. area and color must stay stable
   from enable until done; cells past the right or bottom edge are skipped */
`timescale 1ns/1ps
`include "panel_cfg.svh"

module fill_area (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic                ack,
    input  cmd_pkg::rect_t      area,
    input  panel_pkg::color_t   color,
    output panel_pkg::fb_write_t fb_write,
    output logic                done
);
    import panel_pkg::*;

    localparam pixel_sel_t last_sel_value = pixel_sel_t'(`BYTES_PER_PIXEL - 1);

    row_t       row;
    column_t    col;
    pixel_sel_t sel;
    logic       running;
    logic [8:0] x_end_raw;
    logic [8:0] y_end_raw;
    logic [8:0] x_end;
    logic [8:0] y_end;
    logic       empty;
    logic       last_sel;
    logic       last_col;
    logic       last_row;

    // **********************************************************************
    // Clipped bounds as 9-bit exclusive ends so that x + width cannot wrap
    // **********************************************************************
    assign x_end_raw = {1'b0, area.x} + {1'b0, area.width};
    assign y_end_raw = {1'b0, area.y} + {1'b0, area.height};
    assign x_end = (x_end_raw > 9'(`PANEL_WIDTH)) ? 9'(`PANEL_WIDTH) : x_end_raw;
    assign y_end = (y_end_raw > 9'(`PANEL_HEIGHT)) ? 9'(`PANEL_HEIGHT) : y_end_raw;

    // Nothing to draw if the area is degenerate or starts beyond the panel
    assign empty = (area.width == 8'd0) || (area.height == 8'd0) ||
                   (area.x >= column_t'(`PANEL_WIDTH)) || (area.y >= row_t'(`PANEL_HEIGHT));

    assign last_sel = (sel == last_sel_value);
    assign last_col = ({1'b0, col} == x_end - 9'd1);
    assign last_row = ({1'b0, row} == y_end - 9'd1);

    // **********************************************************************
    // Walk row by row, column by column, byte by byte
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done <= 1'b0;
            row <= '0;
            col <= '0;
            sel <= '0;
        end else if (running) begin
            if (!last_sel) begin
                sel <= sel + 2'd1;
            end else begin
                sel <= '0;
                if (!last_col) begin
                    col <= col + 8'd1;
                end else begin
                    col <= area.x;
                    if (!last_row) begin
                        row <= row + 8'd1;
                    end else begin
                        running <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
        end else if (done) begin
            if (ack) begin
                done <= 1'b0;
            end
        end else if (enable) begin
            row <= area.y;
            col <= area.x;
            sel <= '0;
            if (empty) begin
                done <= 1'b1;
            end else begin
                running <= 1'b1;
            end
        end
    end

    // An idle filler drives all zeros so that the write ports can be ORed
    always_comb begin
        fb_write = '0;
        if (running) begin
            fb_write.addr.row = row;
            fb_write.addr.column = col;
            fb_write.addr.sel = sel;
            fb_write.data = color[sel];
            fb_write.write_en = 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        fb_write.write_en |-> (fb_write.addr.column < column_t'(`PANEL_WIDTH)) &&
                              (fb_write.addr.row < row_t'(`PANEL_HEIGHT)));

    assert property (@(posedge clk) disable iff (reset) done |-> !fb_write.write_en);

endmodule

//--- fill/fill_panel_cmd.sv
/* Fill panel command. Takes BYTES_PER_PIXEL colour bytes, then paints the whole
   panel; arguments are refused until the fill has finished */
`timescale 1ns/1ps
`include "panel_cfg.svh"

module fill_panel_cmd (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           arg_byte,
    input  logic                 arg_valid,
    output logic                 arg_ready,
    output panel_pkg::fb_write_t fb_write,
    output logic                 done
);
    import panel_pkg::*;
    import cmd_pkg::*;

    localparam pixel_sel_t last_byte = pixel_sel_t'(`BYTES_PER_PIXEL - 1);

    pixel_sel_t byte_cnt;
    color_t     color;
    rect_t      area;
    logic       fill_enable;
    logic       fill_done;
    logic       fill_done_q;

    // Whole panel, always from the origin
    assign area = '{
        x:      column_t'(0),
        y:      row_t'(0),
        width:  8'(`PANEL_WIDTH),
        height: 8'(`PANEL_HEIGHT)
    };

    assign arg_ready = ~fill_enable;

    // **********************************************************************
    // Colour capture and fill control
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (arg_valid && arg_ready) begin
            color[byte_cnt] <= arg_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt <= '0;
            fill_enable <= 1'b0;
            fill_done_q <= 1'b0;
        end else begin
            fill_done_q <= fill_done;
            if (done) begin
                fill_enable <= 1'b0;
                byte_cnt <= '0;
            end else if (arg_valid && arg_ready) begin
                if (byte_cnt == last_byte) begin
                    byte_cnt <= '0;
                    fill_enable <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

    // Rising edge of the filler's done level, doubles as its ack
    assign done = fill_done & ~fill_done_q;

    fill_area fill_area_inst (
        .clk      (clk),
        .reset    (reset),
        .enable   (fill_enable),
        .ack      (done),
        .area     (area),
        .color    (color),
        .fb_write (fb_write),
        .done     (fill_done)
    );

endmodule

//--- fill/fill_rect_cmd.sv
/* Fill rectangle command. Arguments are x, y, width, height, then the colour bytes;
   the part of the rectangle beyond the panel is clipped by the filler */
`timescale 1ns/1ps
`include "panel_cfg.svh"

module fill_rect_cmd (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           arg_byte,
    input  logic                 arg_valid,
    output logic                 arg_ready,
    output panel_pkg::fb_write_t fb_write,
    output logic                 done
);
    import panel_pkg::*;
    import cmd_pkg::*;

    localparam int rect_bytes = 4;
    localparam int arg_bytes = rect_bytes + `BYTES_PER_PIXEL;

    typedef logic [$clog2(arg_bytes)-1:0] cnt_t;

    localparam cnt_t last_cnt = cnt_t'(arg_bytes - 1);

    cnt_t   byte_cnt;
    rect_t  area;
    color_t color;
    logic   fill_enable;
    logic   fill_done;
    logic   fill_done_q;

    assign arg_ready = ~fill_enable;

    // **********************************************************************
    // Argument capture, rectangle first and colour after it
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (arg_valid && arg_ready) begin
            case (byte_cnt)
                cnt_t'(0): area.x <= arg_byte;
                cnt_t'(1): area.y <= arg_byte;
                cnt_t'(2): area.width <= arg_byte;
                cnt_t'(3): area.height <= arg_byte;
                default:   color[pixel_sel_t'(byte_cnt - cnt_t'(rect_bytes))] <= arg_byte;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt <= '0;
            fill_enable <= 1'b0;
            fill_done_q <= 1'b0;
        end else begin
            fill_done_q <= fill_done;
            if (done) begin
                fill_enable <= 1'b0;
                byte_cnt <= '0;
            end else if (arg_valid && arg_ready) begin
                if (byte_cnt == last_cnt) begin
                    byte_cnt <= '0;
                    fill_enable <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + cnt_t'(1);
                end
            end
        end
    end

    assign done = fill_done & ~fill_done_q;

    fill_area fill_area_inst (
        .clk      (clk),
        .reset    (reset),
        .enable   (fill_enable),
        .ack      (done),
        .area     (area),
        .color    (color),
        .fb_write (fb_write),
        .done     (fill_done)
    );

    // The decoder must hold off argument bytes for the whole fill
    assert property (@(posedge clk) disable iff (reset) fill_enable |-> !arg_valid);

endmodule

//--- source/cmd_decoder.sv
/* Opcode decoder for the drawing command stream. One command runs at a time and
   unknown opcodes are dropped without any response */
`timescale 1ns/1ps

module cmd_decoder (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] cmd_byte,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    output logic       panel_arg_valid,
    output logic       rect_arg_valid,
    output logic [7:0] arg_byte,
    input  logic       panel_arg_ready,
    input  logic       rect_arg_ready,
    input  logic       panel_done,
    input  logic       rect_done,
    output logic       cmd_done
);
    import cmd_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_forward,
        st_wait
    } state_t;

    state_t  state;
    opcode_t op;
    logic    sel_ready;
    logic    sel_done;
    logic    forward;

    assign sel_ready = (op == OP_FILL_PANEL) ? panel_arg_ready : rect_arg_ready;
    assign sel_done = (op == OP_FILL_PANEL) ? panel_done : rect_done;

    always_comb begin
        case (state)
            st_idle:    cmd_ready = 1'b1;
            st_forward: cmd_ready = sel_ready;
            default:    cmd_ready = 1'b0;
        endcase
    end

    // Argument bytes pass straight through to the selected command
    assign forward = (state == st_forward) && cmd_valid && cmd_ready;
    assign arg_byte = cmd_byte;
    assign panel_arg_valid = forward && (op == OP_FILL_PANEL);
    assign rect_arg_valid = forward && (op == OP_FILL_RECT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            op <= OP_FILL_PANEL;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_valid && (cmd_byte == OP_FILL_PANEL || cmd_byte == OP_FILL_RECT)) begin
                        op <= opcode_t'(cmd_byte);
                        state <= st_forward;
                    end
                end
                // The command lowers arg_ready after its last argument
                st_forward: begin
                    if (!sel_ready) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (sel_done) begin
                        cmd_done <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(panel_arg_valid && rect_arg_valid));

endmodule

//--- source/frame_buffer.sv
/* Byte-wide pixel store with no reset of its contents. Addresses must lie inside
   the panel; read_data follows read_addr by one cycle */
`timescale 1ns/1ps
`include "panel_cfg.svh"

module frame_buffer (
    input  logic                  clk,
    input  panel_pkg::fb_write_t  fb_write,
    input  panel_pkg::pixel_addr_t read_addr,
    output logic [7:0]            read_data
);
    import panel_pkg::*;

    localparam int depth = `PANEL_HEIGHT * `PANEL_WIDTH * `BYTES_PER_PIXEL;
    localparam int index_w = $clog2(depth);

    logic [7:0] mem [depth];

    // Row major, colour bytes of one pixel adjacent
    function automatic logic [index_w-1:0] mem_index(input pixel_addr_t addr);
        int linear;
        linear = (int'(addr.row) * `PANEL_WIDTH + int'(addr.column)) * `BYTES_PER_PIXEL;
        linear = linear + int'(addr.sel);
        return index_w'(linear);
    endfunction

    always_ff @(posedge clk) begin
        if (fb_write.write_en) begin
            mem[mem_index(fb_write.addr)] <= fb_write.data;
        end
    end

    always_ff @(posedge clk) begin
        read_data <= mem[mem_index(read_addr)];
    end

endmodule

//--- source/panel_fill_top.sv
/* Drawing command front end of the LED panel controller. Bytes sent while
   cmd_ready is low are dropped; the read port serves scan-out */
`timescale 1ns/1ps

module panel_fill_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             cmd_byte,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output logic                   cmd_done,
    input  panel_pkg::pixel_addr_t read_addr,
    output logic [7:0]             read_data
);
    import panel_pkg::*;

    logic [7:0] arg_byte;
    logic       panel_arg_valid;
    logic       panel_arg_ready;
    logic       panel_done;
    logic       rect_arg_valid;
    logic       rect_arg_ready;
    logic       rect_done;
    fb_write_t  panel_write;
    fb_write_t  rect_write;
    fb_write_t  fb_write;

    cmd_decoder cmd_decoder_inst (
        .clk             (clk),
        .reset           (reset),
        .cmd_byte        (cmd_byte),
        .cmd_valid       (cmd_valid),
        .cmd_ready       (cmd_ready),
        .panel_arg_valid (panel_arg_valid),
        .rect_arg_valid  (rect_arg_valid),
        .arg_byte        (arg_byte),
        .panel_arg_ready (panel_arg_ready),
        .rect_arg_ready  (rect_arg_ready),
        .panel_done      (panel_done),
        .rect_done       (rect_done),
        .cmd_done        (cmd_done)
    );

    fill_panel_cmd fill_panel_cmd_inst (
        .clk       (clk),
        .reset     (reset),
        .arg_byte  (arg_byte),
        .arg_valid (panel_arg_valid),
        .arg_ready (panel_arg_ready),
        .fb_write  (panel_write),
        .done      (panel_done)
    );

    fill_rect_cmd fill_rect_cmd_inst (
        .clk       (clk),
        .reset     (reset),
        .arg_byte  (arg_byte),
        .arg_valid (rect_arg_valid),
        .arg_ready (rect_arg_ready),
        .fb_write  (rect_write),
        .done      (rect_done)
    );

    // Only one command drives writes at a time, the idle one outputs zero
    assign fb_write = panel_write | rect_write;

    frame_buffer frame_buffer_inst (
        .clk       (clk),
        .fb_write  (fb_write),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

//--- verification/panel_fill_tb.sv
/* Random command stream checked against a frame-buffer model with a full readback
   after each command. The run stops at the first mismatch or timeout */
`timescale 1ns/1ps
`include "panel_cfg.svh"

module panel_fill_tb;
    import panel_pkg::*;
    import cmd_pkg::*;

    localparam int done_timeout = 2000;
    localparam int ready_timeout = 100;

    logic        clk;
    logic        reset;
    logic [7:0]  cmd_byte;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        cmd_done;
    pixel_addr_t read_addr;
    logic [7:0]  read_data;

    // Mirror of the frame buffer, x where nothing has been written yet
    logic [7:0] model_mem [`PANEL_HEIGHT][`PANEL_WIDTH][`BYTES_PER_PIXEL];

    panel_fill_top panel_fill_top_inst (
        .clk       (clk),
        .reset     (reset),
        .cmd_byte  (cmd_byte),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .read_addr (read_addr),
        .read_data (read_data)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Every action of the testbench happens 1 ns after a rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // **********************************************************************
    // Byte stream driving
    // **********************************************************************
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!cmd_ready) begin
            step();
            cycles++;
            if (cycles > ready_timeout) begin
                abort_run("Timeout: cmd_ready stayed low while a byte was waiting to be sent");
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        wait_ready();
        cmd_byte = value;
        cmd_valid = 1'b1;
        step();
        cmd_valid = 1'b0;
    endtask

    // Optionally strobes junk bytes while cmd_ready is low, the DUT must drop them
    task automatic wait_done(input bit junk, output int dropped);
        int cycles;
        cycles = 0;
        dropped = 0;
        while (!cmd_done) begin
            if (junk && !cmd_ready) begin
                cmd_byte = 8'($urandom);
                cmd_valid = 1'b1;
                dropped++;
            end else begin
                cmd_valid = 1'b0;
            end
            step();
            cycles++;
            if (cycles > done_timeout) begin
                abort_run("Timeout: cmd_done never came after a complete command");
            end
        end
        cmd_valid = 1'b0;
    endtask

    // **********************************************************************
    // Model and readback
    // **********************************************************************
    function automatic rect_t make_rect(input int x, input int y, input int w, input int h);
        rect_t area;
        area.x = column_t'(x);
        area.y = row_t'(y);
        area.width = 8'(w);
        area.height = 8'(h);
        return area;
    endfunction

    function automatic color_t random_color();
        color_t color;
        for (int s = 0; s < `BYTES_PER_PIXEL; s++) begin
            color[s] = 8'($urandom);
        end
        return color;
    endfunction

    // Cells past the right or bottom edge are clipped away
    function automatic void model_fill(input rect_t area, input color_t color);
        int r;
        int c;
        for (r = int'(area.y); r < int'(area.y) + int'(area.height); r++) begin
            for (c = int'(area.x); c < int'(area.x) + int'(area.width); c++) begin
                if (r < `PANEL_HEIGHT && c < `PANEL_WIDTH) begin
                    for (int s = 0; s < `BYTES_PER_PIXEL; s++) begin
                        model_mem[r][c][s] = color[s];
                    end
                end
            end
        end
    endfunction

    task automatic check_byte(input pixel_addr_t addr, output logic [7:0] got);
        logic [7:0] expected;
        expected = model_mem[addr.row][addr.column][addr.sel];
        read_addr = addr;
        step();
        got = read_data;
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: row %0d col %0d byte %0d read %h, expected %h",
                                $time, addr.row, addr.column, addr.sel, got, expected));
        end
    endtask

    task automatic check_pixel(input pixel_addr_t addr);
        pixel_addr_t byte_addr;
        color_t      got;
        color_t      expected;
        logic [7:0]  value;
        byte_addr = addr;
        for (int s = 0; s < `BYTES_PER_PIXEL; s++) begin
            byte_addr.sel = pixel_sel_t'(s);
            check_byte(byte_addr, value);
            got[s] = value;
            expected[s] = model_mem[addr.row][addr.column][s];
        end
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: pixel row %0d col %0d is %h, expected %h",
                                $time, addr.row, addr.column, got, expected));
        end
    endtask

    task automatic read_all();
        pixel_addr_t addr;
        addr = '0;
        for (int r = 0; r < `PANEL_HEIGHT; r++) begin
            for (int c = 0; c < `PANEL_WIDTH; c++) begin
                addr.row = row_t'(r);
                addr.column = column_t'(c);
                check_pixel(addr);
            end
        end
    endtask

    task automatic run_panel(input color_t color, input bit junk, output int dropped);
        send_byte(OP_FILL_PANEL);
        for (int s = 0; s < `BYTES_PER_PIXEL; s++) begin
            send_byte(color[s]);
        end
        wait_done(junk, dropped);
        model_fill(make_rect(0, 0, `PANEL_WIDTH, `PANEL_HEIGHT), color);
        read_all();
    endtask

    task automatic run_rect(input rect_t area, input color_t color, input bit junk,
                            output int dropped);
        send_byte(OP_FILL_RECT);
        send_byte(area.x);
        send_byte(area.y);
        send_byte(area.width);
        send_byte(area.height);
        for (int s = 0; s < `BYTES_PER_PIXEL; s++) begin
            send_byte(color[s]);
        end
        wait_done(junk, dropped);
        model_fill(area, color);
        read_all();
    endtask

    // **********************************************************************
    // Test sequence
    // **********************************************************************
    initial begin
        rect_t      area;
        int         dropped;
        int         x;
        int         y;
        logic [7:0] bad_op;

        void'($urandom(12828));
        clk = 1'b0;
        reset = 1'b1;
        cmd_byte = '0;
        cmd_valid = 1'b0;
        read_addr = '0;
        for (int r = 0; r < `PANEL_HEIGHT; r++) begin
            for (int c = 0; c < `PANEL_WIDTH; c++) begin
                for (int s = 0; s < `BYTES_PER_PIXEL; s++) begin
                    model_mem[r][c][s] = 'x;
                end
            end
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        step();

        run_panel(random_color(), 1'b0, dropped);

        // Rectangles fully inside the panel
        repeat (4) begin
            x = $urandom % `PANEL_WIDTH;
            y = $urandom % `PANEL_HEIGHT;
            area = make_rect(x, y, 1 + $urandom % (`PANEL_WIDTH - x),
                             1 + $urandom % (`PANEL_HEIGHT - y));
            run_rect(area, random_color(), 1'b0, dropped);
        end

        // Clipped, off-panel and empty rectangles
        run_rect(make_rect(12, 5, 10, 10), random_color(), 1'b0, dropped);
        run_rect(make_rect(3, 2, 40, 1), random_color(), 1'b0, dropped);
        run_rect(make_rect(20, 2, 4, 4), random_color(), 1'b0, dropped);
        run_rect(make_rect(3, 9, 4, 4), random_color(), 1'b0, dropped);
        run_rect(make_rect(250, 0, 20, 3), random_color(), 1'b0, dropped);
        run_rect(make_rect(4, 4, 0, 3), random_color(), 1'b0, dropped);
        run_rect(make_rect(4, 4, 3, 0), random_color(), 1'b0, dropped);

        // Unknown opcode gives no response and leaves the decoder idle
        bad_op = 8'($urandom);
        while (bad_op == 8'h01 || bad_op == 8'h02) begin
            bad_op = 8'($urandom);
        end
        send_byte(bad_op);
        repeat (20) begin
            if (cmd_done) begin
                abort_run("An unknown opcode produced cmd_done");
            end
            if (!cmd_ready) begin
                abort_run("cmd_ready dropped after an unknown opcode");
            end
            step();
        end
        run_rect(make_rect(1, 1, 5, 3), random_color(), 1'b0, dropped);

        // Junk bytes strobed during fills must leave no trace
        run_panel(random_color(), 1'b1, dropped);
        if (dropped == 0) begin
            abort_run("No bytes were strobed while cmd_ready was low during the panel fill");
        end
        run_rect(make_rect(2, 1, 9, 6), random_color(), 1'b1, dropped);
        if (dropped == 0) begin
            abort_run("No bytes were strobed while cmd_ready was low during the rectangle fill");
        end

        repeat (40) begin
            if ($urandom % 4 == 0) begin
                run_panel(random_color(), 1'($urandom), dropped);
            end else begin
                area = make_rect($urandom % 20, $urandom % 12, $urandom % 20, $urandom % 12);
                run_rect(area, random_color(), 1'($urandom), dropped);
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+common
common/panel_pkg.sv
common/cmd_pkg.sv
fill/fill_area.sv
fill/fill_panel_cmd.sv
fill/fill_rect_cmd.sv
source/cmd_decoder.sv
source/frame_buffer.sv
source/panel_fill_top.sv
verification/panel_fill_tb.sv
